// ==== src.f ====
src/mipsPkg.sv
src/pipeIfs.sv
src/regFile.sv
src/aluUnit.sv
src/mulUnit.sv
src/mipsControl.sv
src/mipsDatapath.sv
src/mipsCore.sv
sim/clockGen.sv
sim/mipsCoreTb.sv

// ==== sim/mipsCoreTb.sv ====
`timescale 1ns/100ps

module mipsCoreTb;

  import mipsPkg::*;

  // Instruction count of all programs times 40 cycles
  localparam int TimeoutCycles = (15 + 13 + 24 + 9) * 40;

  logic Clk;
  logic rst;
  logic restart;
  wordT imemAddr, imemData, dmemAddr, dmemWData, dmemRData, wbData;
  logic dmemWrite, wbEn;
  regAddrT wbAddr;

  wordT imem [256];
  wordT dmem [256];
  wordT prog [$];
  regAddrT expAddr [$];
  regAddrT gotAddr [$];
  wordT expData [$];
  wordT gotData [$];
  integer seed = 32'h1ac5ee20;
  int errorCount = 0;
  int testStart = 0;
  int testCount = 0;
  int failedTests = 0;
  int cycleCount = 0;

  clockGen clocks (.restart, .Clk, .rst);

  mipsCore dut_i (
    .Clk, .rst, .imemAddr, .imemData,
    .dmemAddr, .dmemWData, .dmemWrite, .dmemRData,
    .wbEn, .wbAddr, .wbData
  );

  assign imemData = imem[imemAddr[9:2]];
  assign dmemRData = dmem[dmemAddr[9:2]];

  always @(posedge Clk) begin
    if (dmemWrite) dmem[dmemAddr[9:2]] <= dmemWData;
  end

  // One retirement entry per write-back pulse
  always @(negedge Clk) begin
    if (!rst && wbEn) begin
      gotAddr.push_back(wbAddr);
      gotData.push_back(wbData);
    end
  end

  always @(posedge Clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: run stopped after %0d cycles", cycleCount);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic wordT encR(functE fn, regAddrT rs, regAddrT rt, regAddrT rd,
                                logic [4:0] sh);
    return {OpSpecial, rs, rt, rd, sh, fn};
  endfunction

  function automatic wordT encI(opcodeE op, regAddrT rs, regAddrT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Index is a word offset from the reset address
  function automatic wordT encJ(opcodeE op, int index);
    wordT target;
    target = ResetPc + 32'(index) * 32'd4;
    return {op, target[27:2]};
  endfunction

  function automatic wordT signExt16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic wordT dmemFill(int i);
    wordT a;
    a = 32'(i);
    return {16'hd0d0, ~a[7:0], a[7:0]};
  endfunction

  task automatic checkWord(input string name, input wordT expected, input wordT actual);
    assert (actual === expected) else begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic expectWrite(input regAddrT addr, input wordT data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic beginTest();
    prog.delete();
    expAddr.delete();
    expData.delete();
    testStart = errorCount;
  endtask

  task automatic finishTest(input string name);
    testCount++;
    if (errorCount == testStart) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: %0d check(s) failed", name, errorCount - testStart);
    end
  endtask

  // Jump-to-self with a nop in its delay slot
  task automatic endProgram();
    prog.push_back(encJ(OpJ, prog.size()));
    prog.push_back(32'h0000_0000);
  endtask

  task automatic loadMemories();
    int i;
    for (i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
      dmem[i] = dmemFill(i);
    end
  endtask

  task automatic applyReset(input bit checkIt);
    @(posedge Clk);
    restart <= 1'b1;
    @(posedge Clk);
    restart <= 1'b0;
    // DUT is in reset from this edge on
    @(posedge Clk);
    @(negedge Clk);
    loadMemories();
    do begin
      @(negedge Clk);
      if (checkIt) begin
        checkWord("wbEn", 32'h0, {31'b0, wbEn});
        checkWord("dmemWrite", 32'h0, {31'b0, dmemWrite});
      end
    end while (rst);
    if (checkIt) checkWord("imemAddr", ResetPc, imemAddr);
    gotAddr.delete();
    gotData.delete();
  endtask

  task automatic runProgram();
    endProgram();
    applyReset(1'b0);
    while (gotData.size() < expData.size()) @(posedge Clk);
    // Room for a stray write still in the pipeline to show up
    repeat (5) @(posedge Clk);
  endtask

  task automatic compareWrites();
    int i;
    assert (gotData.size() == expData.size()) else begin
      $display("Retired %0d register writes but %0d were expected",
               gotData.size(), expData.size());
      errorCount++;
    end
    for (i = 0; i < expData.size() && i < gotData.size(); i++) begin
      checkWord($sformatf("wbAddr[%0d]", i), {27'b0, expAddr[i]}, {27'b0, gotAddr[i]});
      checkWord($sformatf("wbData[%0d]", i), expData[i], gotData[i]);
    end
  endtask

  task automatic resetTest();
    beginTest();
    applyReset(1'b1);
    finishTest("reset");
  endtask

  task automatic aluChainTest();
    logic [15:0] immA, immB, immC, immD, immE;
    logic [4:0] shA, shB;
    wordT r [14];
    int i;
    beginTest();
    immA = 16'($random(seed));
    immB = 16'($random(seed));
    immC = 16'($random(seed));
    immD = 16'($random(seed));
    immE = 16'($random(seed));
    shA = 5'($random(seed));
    shB = 5'($random(seed));
    r[1] = signExt16(immA);
    r[2] = r[1] + signExt16(immB);
    r[3] = r[2] + r[1];
    r[4] = r[2] - r[3];
    r[5] = r[4] & r[3];
    r[6] = r[5] | r[2];
    r[7] = r[6] << shA;
    r[8] = r[7] >> shB;
    r[9] = ($signed(r[8]) < $signed(r[3])) ? 32'd1 : 32'd0;
    r[10] = {immC, 16'h0000};
    r[11] = r[10] | {16'h0000, immD};
    r[12] = r[11] + r[9];
    r[13] = r[12] & {16'h0000, immE};
    prog.push_back(encI(OpAddiu, 0, 1, immA));
    prog.push_back(encI(OpAddiu, 1, 2, immB));
    prog.push_back(encR(FnAddu, 2, 1, 3, 0));
    prog.push_back(encR(FnSubu, 2, 3, 4, 0));
    prog.push_back(encR(FnAnd, 4, 3, 5, 0));
    prog.push_back(encR(FnOr, 5, 2, 6, 0));
    prog.push_back(encR(FnSll, 0, 6, 7, shA));
    prog.push_back(encR(FnSrl, 0, 7, 8, shB));
    prog.push_back(encR(FnSlt, 8, 3, 9, 0));
    prog.push_back(encI(OpLui, 0, 10, immC));
    prog.push_back(encI(OpOri, 10, 11, immD));
    prog.push_back(encR(FnAddu, 11, 9, 12, 0));
    prog.push_back(encI(OpAndi, 12, 13, immE));
    for (i = 1; i <= 13; i++) expectWrite(5'(i), r[i]);
    runProgram();
    compareWrites();
    finishTest("alu chain");
  endtask

  task automatic memoryTest();
    logic [15:0] immA, immB;
    wordT r1, r2, r3, r5, r7;
    beginTest();
    immA = 16'($random(seed));
    immB = 16'($random(seed));
    r1 = signExt16(immA);
    r2 = {immB, 16'h0000};
    r3 = r2 | r1;
    r5 = r1 + r3;
    r7 = r3 - r1;
    prog.push_back(encI(OpAddiu, 0, 1, immA));
    prog.push_back(encI(OpLui, 0, 2, immB));
    prog.push_back(encR(FnOr, 2, 1, 3, 0));
    prog.push_back(encI(OpSw, 0, 1, 16'h0040));
    prog.push_back(encI(OpSw, 0, 3, 16'h0044));
    prog.push_back(encI(OpLw, 0, 4, 16'h0040));
    prog.push_back(encR(FnAddu, 4, 3, 5, 0));
    prog.push_back(encI(OpLw, 0, 6, 16'h0044));
    prog.push_back(encR(FnSubu, 6, 4, 7, 0));
    prog.push_back(encI(OpSw, 0, 7, 16'h0048));
    prog.push_back(encI(OpLw, 0, 8, 16'h0048));
    expectWrite(1, r1);
    expectWrite(2, r2);
    expectWrite(3, r3);
    expectWrite(4, r1);
    expectWrite(5, r5);
    expectWrite(6, r3);
    expectWrite(7, r7);
    expectWrite(8, r7);
    runProgram();
    compareWrites();
    checkWord("dmem[16]", r1, dmem[16]);
    checkWord("dmem[17]", r3, dmem[17]);
    checkWord("dmem[18]", r7, dmem[18]);
    checkWord("dmem[19]", dmemFill(19), dmem[19]);
    finishTest("memory");
  endtask

  // Branch offsets count words from the delay slot
  task automatic controlFlowTest();
    beginTest();
    prog.push_back(encI(OpAddiu, 0, 1, 16'd5));
    prog.push_back(encI(OpAddiu, 0, 2, 16'd5));
    prog.push_back(encI(OpBeq, 1, 2, 16'd2));
    prog.push_back(encI(OpAddiu, 0, 3, 16'd1));
    prog.push_back(encI(OpAddiu, 0, 4, 16'd99));
    prog.push_back(encI(OpBne, 1, 2, 16'd3));
    prog.push_back(encI(OpAddiu, 0, 5, 16'd2));
    prog.push_back(encI(OpAddiu, 0, 6, 16'd3));
    prog.push_back(encI(OpBne, 1, 6, 16'd2));
    prog.push_back(encI(OpAddiu, 0, 7, 16'd4));
    prog.push_back(encI(OpAddiu, 0, 8, 16'd98));
    prog.push_back(encI(OpBeq, 1, 6, 16'd8));
    prog.push_back(encI(OpAddiu, 0, 9, 16'd5));
    prog.push_back(encJ(OpJal, 17));
    prog.push_back(encI(OpAddiu, 0, 10, 16'd6));
    // Return lands here and leaves for the end loop
    prog.push_back(encJ(OpJ, 22));
    prog.push_back(encI(OpAddiu, 0, 13, 16'd8));
    // Subroutine
    prog.push_back(encI(OpAddiu, 0, 11, 16'd7));
    prog.push_back(encR(FnJr, 31, 0, 0, 0));
    prog.push_back(encI(OpAddiu, 0, 12, 16'd9));
    prog.push_back(encI(OpAddiu, 0, 14, 16'd95));
    prog.push_back(32'h0000_0000);
    expectWrite(1, 32'd5);
    expectWrite(2, 32'd5);
    expectWrite(3, 32'd1);
    expectWrite(5, 32'd2);
    expectWrite(6, 32'd3);
    expectWrite(7, 32'd4);
    expectWrite(9, 32'd5);
    expectWrite(31, ResetPc + 32'd13 * 32'd4 + 32'd8);
    expectWrite(10, 32'd6);
    expectWrite(11, 32'd7);
    expectWrite(12, 32'd9);
    expectWrite(13, 32'd8);
    runProgram();
    compareWrites();
    finishTest("control flow");
  endtask

  task automatic multiplyTest();
    wordT a, b;
    logic [63:0] prod;
    beginTest();
    a = $random(seed);
    b = $random(seed);
    prod = {32'h0, a} * {32'h0, b};
    prog.push_back(encI(OpLui, 0, 1, a[31:16]));
    prog.push_back(encI(OpOri, 1, 1, a[15:0]));
    prog.push_back(encI(OpLui, 0, 2, b[31:16]));
    prog.push_back(encI(OpOri, 2, 2, b[15:0]));
    prog.push_back(encR(FnMultu, 1, 2, 0, 0));
    prog.push_back(encR(FnMflo, 0, 0, 3, 0));
    prog.push_back(encR(FnMfhi, 0, 0, 4, 0));
    expectWrite(1, {a[31:16], 16'h0000});
    expectWrite(1, a);
    expectWrite(2, {b[31:16], 16'h0000});
    expectWrite(2, b);
    expectWrite(3, prod[31:0]);
    expectWrite(4, prod[63:32]);
    runProgram();
    compareWrites();
    finishTest("multiply");
  endtask

  initial begin
    restart = 1'b0;
    loadMemories();
    resetTest();
    aluChainTest();
    memoryTest();
    controlFlowTest();
    multiplyTest();
    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             testCount, failedTests, errorCount);
    if (errorCount == 0) $display("Done: no errors");
    else $display("Done: errors found");
    $finish;
  end

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
  input logic restart,
  output logic Clk,
  output logic rst
);

  logic [2:0] rstCount;

  // 20 ns period
  initial begin
    Clk = 1'b0;
    forever #10 Clk = ~Clk;
  end

  initial rstCount = 3'd5;

  // Reset covers 5 rising edges after power-up or a restart request
  always @(posedge Clk) begin
    if (restart) rstCount <= 3'd5;
    else if (rstCount != 3'd0) rstCount <= rstCount - 3'd1;
  end

  assign rst = (rstCount != 3'd0);

endmodule

// ==== src/mipsCore.sv ====
`timescale 1ns/100ps

module mipsCore (
  input logic Clk,
  input logic rst,
  output mipsPkg::wordT imemAddr,
  input mipsPkg::wordT imemData,
  output mipsPkg::wordT dmemAddr,
  output mipsPkg::wordT dmemWData,
  output logic dmemWrite,
  input mipsPkg::wordT dmemRData,
  output logic wbEn,
  output mipsPkg::regAddrT wbAddr,
  output mipsPkg::wordT wbData
);

  decodeIf dec ();
  hazardIf haz ();

  mipsControl uControl (.Clk, .rst, .dec(dec.ctl), .haz(haz.ctl));

  mipsDatapath uDatapath (
    .Clk, .rst, .dec(dec.dp), .haz(haz.dp),
    .imemAddr, .imemData,
    .dmemAddr, .dmemWData, .dmemWrite, .dmemRData,
    .wbEn, .wbAddr, .wbData
  );

endmodule

// ==== src/mipsDatapath.sv ====
`timescale 1ns/100ps

module mipsDatapath (
  input logic Clk,
  input logic rst,
  decodeIf.dp dec,
  hazardIf.dp haz,
  output mipsPkg::wordT imemAddr,
  input mipsPkg::wordT imemData,
  output mipsPkg::wordT dmemAddr,
  output mipsPkg::wordT dmemWData,
  output logic dmemWrite,
  input mipsPkg::wordT dmemRData,
  output logic wbEn,
  output mipsPkg::regAddrT wbAddr,
  output mipsPkg::wordT wbData
);

  import mipsPkg::*;

  function automatic wordT fwdMux(fwdSelE sel, wordT rf, wordT exMem, wordT memWb);
    case (sel)
      FwdExMem: return exMem;
      FwdMemWb: return memWb;
      default: return rf;
    endcase
  endfunction

  wordT pc, pcPlus4, nextPc;
  logic idValid;
  wordT idInstr, idPc4, rfA, rfB, opA, opB, extImm, branchTarget, jumpTarget;
  logic link;
  logic exValid, exRegWrite, exMemRead, exMemWrite, exMulStart, exAluSrcImm, exLink;
  aluOpE exAluOp;
  wbSelE exWbSel;
  fwdSelE exFwdA, exFwdB;
  regAddrT exDest;
  logic [4:0] exShamt;
  wordT exA, exB, exImm, exPc8, srcA, srcB, aluB, aluY, hi, lo, exResult;
  logic mulBusy;
  logic memValid, memRegWrite, memMemRead, memMemWrite;
  wbSelE memWbSel;
  regAddrT memDest;
  wordT memResult, memStore;
  logic wbValid, wbRegWrite;
  wbSelE wbWbSel;
  wordT wbResult, wbMemData;

  // IF
  assign imemAddr = pc;
  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge Clk) begin
    if (rst) pc <= ResetPc;
    else if (!haz.stall) pc <= nextPc;
  end

  always_ff @(posedge Clk) begin
    if (rst) idValid <= 1'b0;
    else if (!haz.stall) idValid <= 1'b1;
  end

  always_ff @(posedge Clk) begin
    if (!haz.stall) begin
      idInstr <= imemData;
      idPc4 <= pcPlus4;
    end
  end

  // ID
  // An empty slot decodes as a no-op
  assign dec.instr = idValid ? idInstr : '0;

  regFile uRegFile (.Clk, .rst, .raddrA(dec.instr[25:21]), .raddrB(dec.instr[20:16]),
                    .waddr(wbAddr), .wdata(wbData), .we(wbEn), .rdataA(rfA), .rdataB(rfB));

  assign opA = fwdMux(haz.idFwdA, rfA, memResult, wbData);
  assign opB = fwdMux(haz.idFwdB, rfB, memResult, wbData);
  assign extImm = dec.signExt ? {{16{dec.instr[15]}}, dec.instr[15:0]}
                              : {16'h0000, dec.instr[15:0]};
  assign branchTarget = idPc4 + {extImm[29:0], 2'b00};
  assign jumpTarget = {idPc4[31:28], dec.instr[25:0], 2'b00};
  assign link = (dec.pcSrc == PcJump) && dec.regWrite;

  always_comb begin
    nextPc = pcPlus4;
    case (dec.pcSrc)
      PcBeq: if (opA == opB) nextPc = branchTarget;
      PcBne: if (opA != opB) nextPc = branchTarget;
      PcJump: nextPc = jumpTarget;
      PcJr: nextPc = opA;
      default: ;
    endcase
  end

  always_ff @(posedge Clk) begin
    if (rst) exValid <= 1'b0;
    else exValid <= idValid && !haz.stall;
  end

  always_ff @(posedge Clk) begin
    {exRegWrite, exMemRead, exMemWrite} <= {dec.regWrite, dec.memRead, dec.memWrite};
    {exMulStart, exAluSrcImm, exLink} <= {dec.mulStart, dec.aluSrcImm, link};
    exAluOp <= dec.aluOp;
    exWbSel <= dec.wbSel;
    exFwdA <= haz.exFwdA;
    exFwdB <= haz.exFwdB;
    exDest <= dec.destReg;
    exShamt <= dec.instr[10:6];
    exA <= rfA;
    exB <= rfB;
    exImm <= extImm;
    exPc8 <= idPc4 + 32'd4;
  end

  // EX
  assign srcA = fwdMux(exFwdA, exA, memResult, wbData);
  assign srcB = fwdMux(exFwdB, exB, memResult, wbData);
  assign aluB = exAluSrcImm ? exImm : srcB;

  aluUnit uAlu (.op(exAluOp), .a(srcA), .b(aluB), .shamt(exShamt), .y(aluY));

  mulUnit uMul (.Clk, .rst, .start(exValid && exMulStart), .a(srcA), .b(srcB),
                .busy(mulBusy), .hi, .lo);

  always_comb begin
    case (exWbSel)
      WbHi: exResult = hi;
      WbLo: exResult = lo;
      default: exResult = aluY;
    endcase
    if (exLink) exResult = exPc8;
  end

  assign haz.exDest = exDest;
  assign haz.exRegWrite = exValid && exRegWrite;
  assign haz.exMemRead = exValid && exMemRead;
  // A multu still in EX counts as busy
  assign haz.mulBusy = mulBusy || (exValid && exMulStart);

  always_ff @(posedge Clk) begin
    if (rst) memValid <= 1'b0;
    else memValid <= exValid;
  end

  always_ff @(posedge Clk) begin
    {memRegWrite, memMemRead, memMemWrite} <= {exRegWrite, exMemRead, exMemWrite};
    memWbSel <= exWbSel;
    memDest <= exDest;
    memResult <= exResult;
    memStore <= srcB;
  end

  // MEM
  assign dmemAddr = memResult;
  assign dmemWData = memStore;
  assign dmemWrite = memValid && memMemWrite;
  assign haz.memDest = memDest;
  assign haz.memRegWrite = memValid && memRegWrite;
  assign haz.memMemRead = memValid && memMemRead;

  always_ff @(posedge Clk) begin
    if (rst) wbValid <= 1'b0;
    else wbValid <= memValid;
  end

  always_ff @(posedge Clk) begin
    wbRegWrite <= memRegWrite;
    wbWbSel <= memWbSel;
    wbAddr <= memDest;
    wbResult <= memResult;
    wbMemData <= dmemRData;
  end

  // WB
  assign wbEn = wbValid && wbRegWrite;
  assign wbData = (wbWbSel == WbMem) ? wbMemData : wbResult;

  assert property (@(posedge Clk) disable iff (rst) dmemWrite |-> !(memValid && memMemRead));

endmodule

// ==== src/mipsControl.sv ====
`timescale 1ns/100ps

module mipsControl (
  input logic Clk,
  input logic rst,
  decodeIf.ctl dec,
  hazardIf.ctl haz
);

  import mipsPkg::*;

  opcodeE opcode;
  functE funct;
  regAddrT rs;
  regAddrT rt;
  regAddrT dest;
  logic writeReg;
  logic usesRs;
  logic usesRt;
  logic mulUse;
  logic idCompare;
  logic exHitA;
  logic exHitB;
  logic memHitA;
  logic memHitB;
  logic loadUse;
  logic branchHaz;
  logic mulHaz;

  assign opcode = opcodeE'(dec.instr[31:26]);
  assign funct = functE'(dec.instr[5:0]);
  assign rs = dec.instr[25:21];
  assign rt = dec.instr[20:16];

  always_comb begin
    dec.aluOp = AluAdd;
    dec.aluSrcImm = 1'b0;
    dec.signExt = 1'b1;
    dec.wbSel = WbAlu;
    dec.memRead = 1'b0;
    dec.memWrite = 1'b0;
    dec.pcSrc = PcSeq;
    dec.mulStart = 1'b0;
    writeReg = 1'b0;
    dest = dec.instr[15:11];
    usesRs = 1'b0;
    usesRt = 1'b0;
    mulUse = 1'b0;
    case (opcode)
      OpSpecial: begin
        case (funct)
          FnSubu: dec.aluOp = AluSub;
          FnAnd: dec.aluOp = AluAnd;
          FnOr: dec.aluOp = AluOr;
          FnSlt: dec.aluOp = AluSlt;
          FnSll: dec.aluOp = AluSll;
          FnSrl: dec.aluOp = AluSrl;
          default: dec.aluOp = AluAdd;
        endcase
        case (funct)
          FnAddu, FnSubu, FnAnd, FnOr, FnSlt: begin
            writeReg = 1'b1;
            usesRs = 1'b1;
            usesRt = 1'b1;
          end
          FnSll, FnSrl: begin
            writeReg = 1'b1;
            usesRt = 1'b1;
          end
          FnJr: begin
            dec.pcSrc = PcJr;
            usesRs = 1'b1;
          end
          FnMfhi, FnMflo: begin
            writeReg = 1'b1;
            dec.wbSel = (funct == FnMfhi) ? WbHi : WbLo;
            mulUse = 1'b1;
          end
          FnMultu: begin
            dec.mulStart = 1'b1;
            usesRs = 1'b1;
            usesRt = 1'b1;
            mulUse = 1'b1;
          end
          default: ;
        endcase
      end
      OpAddiu, OpAndi, OpOri, OpLui, OpLw: begin
        writeReg = 1'b1;
        dest = rt;
        dec.aluSrcImm = 1'b1;
        usesRs = (opcode != OpLui);
        dec.signExt = (opcode == OpAddiu) || (opcode == OpLw);
        if (opcode == OpAndi) dec.aluOp = AluAnd;
        if (opcode == OpOri) dec.aluOp = AluOr;
        if (opcode == OpLui) dec.aluOp = AluLui;
        if (opcode == OpLw) begin
          dec.memRead = 1'b1;
          dec.wbSel = WbMem;
        end
      end
      OpSw: begin
        dec.memWrite = 1'b1;
        dec.aluSrcImm = 1'b1;
        usesRs = 1'b1;
        usesRt = 1'b1;
      end
      OpBeq, OpBne: begin
        dec.pcSrc = (opcode == OpBeq) ? PcBeq : PcBne;
        usesRs = 1'b1;
        usesRt = 1'b1;
      end
      OpJ: dec.pcSrc = PcJump;
      OpJal: begin
        dec.pcSrc = PcJump;
        writeReg = 1'b1;
        dest = LinkReg;
      end
      default: ;
    endcase
  end

  // Writes to register 0 are dropped here so hazards ignore them
  assign dec.regWrite = writeReg && (dest != '0);
  assign dec.destReg = dest;

  assign exHitA = usesRs && (rs != '0) && haz.exRegWrite && (haz.exDest == rs);
  assign exHitB = usesRt && (rt != '0) && haz.exRegWrite && (haz.exDest == rt);
  assign memHitA = usesRs && (rs != '0) && haz.memRegWrite && (haz.memDest == rs);
  assign memHitB = usesRt && (rt != '0) && haz.memRegWrite && (haz.memDest == rt);

  // Branch and jr operands are compared in ID
  assign idCompare = (dec.pcSrc == PcBeq) || (dec.pcSrc == PcBne) || (dec.pcSrc == PcJr);

  assign loadUse = haz.exMemRead && (exHitA || exHitB);
  assign branchHaz = idCompare && (exHitA || exHitB ||
                                   (haz.memMemRead && (memHitA || memHitB)));
  assign mulHaz = mulUse && haz.mulBusy;
  assign haz.stall = loadUse || branchHaz || mulHaz;

  assign haz.idFwdA = memHitA ? FwdExMem : FwdReg;
  assign haz.idFwdB = memHitB ? FwdExMem : FwdReg;
  // Selects for the next cycle, when EX has moved to MEM and MEM to WB
  assign haz.exFwdA = exHitA ? FwdExMem : (memHitA ? FwdMemWb : FwdReg);
  assign haz.exFwdB = exHitB ? FwdExMem : (memHitB ? FwdMemWb : FwdReg);

  assert property (@(posedge Clk) disable iff (rst) $rose(haz.stall) |-> (dec.instr != '0));

endmodule

// ==== src/mulUnit.sv ====
`timescale 1ns/100ps

module mulUnit (
  input logic Clk,
  input logic rst,
  input logic start,
  input mipsPkg::wordT a,
  input mipsPkg::wordT b,
  output logic busy,
  output mipsPkg::wordT hi,
  output mipsPkg::wordT lo
);

  import mipsPkg::*;

  logic [5:0] count;
  wordT mcand;
  logic [63:0] prod;
  logic [32:0] partial;

  // Upper half plus multiplicand when the current multiplier bit is set
  assign partial = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);

  always_ff @(posedge Clk) begin
    if (rst) begin
      busy <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      count <= MulCycles;
    end else if (busy) begin
      if (count == '0) busy <= 1'b0;
      else count <= count - 6'd1;
    end
  end

  // Multiplier sits in the low half and shifts out as the product shifts in
  always_ff @(posedge Clk) begin
    if (start) begin
      mcand <= a;
      prod <= {32'h0000_0000, b};
    end else if (busy && (count != '0)) begin
      prod <= {partial, prod[31:1]};
    end
  end

  assign hi = prod[63:32];
  assign lo = prod[31:0];

  assert property (@(posedge Clk) disable iff (rst) busy |-> !start);

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
  input mipsPkg::aluOpE op,
  input mipsPkg::wordT a,
  input mipsPkg::wordT b,
  input logic [4:0] shamt,
  output mipsPkg::wordT y
);

  import mipsPkg::*;

  always_comb begin
    case (op)
      AluAdd: y = a + b;
      AluSub: y = a - b;
      AluAnd: y = a & b;
      AluOr: y = a | b;
      AluSlt: y = {31'b0, $signed(a) < $signed(b)};
      // Shifts act on the rt operand
      AluSll: y = b << shamt;
      AluSrl: y = b >> shamt;
      AluLui: y = {b[15:0], 16'h0000};
      default: y = '0;
    endcase
  end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/100ps

module regFile (
  input logic Clk,
  input logic rst,
  input mipsPkg::regAddrT raddrA,
  input mipsPkg::regAddrT raddrB,
  input mipsPkg::regAddrT waddr,
  input mipsPkg::wordT wdata,
  input logic we,
  output mipsPkg::wordT rdataA,
  output mipsPkg::wordT rdataB
);

  import mipsPkg::*;

  wordT regs [32];

  always_ff @(posedge Clk) begin
    if (rst) regs <= '{default: '0};
    else if (we && (waddr != '0)) regs[waddr] <= wdata;
  end

  // Write-through so WB and ID can share a cycle
  assign rdataA = (raddrA == '0) ? '0 :
                  (we && (waddr == raddrA)) ? wdata : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 :
                  (we && (waddr == raddrB)) ? wdata : regs[raddrB];

endmodule

// ==== src/pipeIfs.sv ====
`timescale 1ns/100ps

interface decodeIf;
  import mipsPkg::*;

  wordT instr;
  aluOpE aluOp;
  logic aluSrcImm;
  logic signExt;
  logic regWrite;
  regAddrT destReg;
  wbSelE wbSel;
  logic memRead;
  logic memWrite;
  pcSrcE pcSrc;
  logic mulStart;

  modport ctl (input instr, output aluOp, aluSrcImm, signExt, regWrite, destReg, wbSel,
               memRead, memWrite, pcSrc, mulStart);
  modport dp (output instr, input aluOp, aluSrcImm, signExt, regWrite, destReg, wbSel,
              memRead, memWrite, pcSrc, mulStart);
endinterface

interface hazardIf;
  import mipsPkg::*;

  regAddrT exDest;
  logic exRegWrite;
  logic exMemRead;
  regAddrT memDest;
  logic memRegWrite;
  logic memMemRead;
  logic mulBusy;
  logic stall;
  fwdSelE idFwdA;
  fwdSelE idFwdB;
  fwdSelE exFwdA;
  fwdSelE exFwdB;

  modport ctl (input exDest, exRegWrite, exMemRead, memDest, memRegWrite, memMemRead, mulBusy,
               output stall, idFwdA, idFwdB, exFwdA, exFwdB);
  modport dp (output exDest, exRegWrite, exMemRead, memDest, memRegWrite, memMemRead, mulBusy,
              input stall, idFwdA, idFwdB, exFwdA, exFwdB);
endinterface

// ==== src/mipsPkg.sv ====
package mipsPkg;

  typedef logic [4:0] regAddrT;
  typedef logic [31:0] wordT;

  localparam wordT ResetPc = 32'h0000_0000;
  localparam regAddrT LinkReg = 5'd31;
  localparam logic [5:0] MulCycles = 6'd32;

  typedef enum logic [5:0] {
    OpSpecial = 6'h00,
    OpJ       = 6'h02,
    OpJal     = 6'h03,
    OpBeq     = 6'h04,
    OpBne     = 6'h05,
    OpAddiu   = 6'h09,
    OpAndi    = 6'h0c,
    OpOri     = 6'h0d,
    OpLui     = 6'h0f,
    OpLw      = 6'h23,
    OpSw      = 6'h2b
  } opcodeE;

  typedef enum logic [5:0] {
    FnSll   = 6'h00,
    FnSrl   = 6'h02,
    FnJr    = 6'h08,
    FnMfhi  = 6'h10,
    FnMflo  = 6'h12,
    FnMultu = 6'h19,
    FnAddu  = 6'h21,
    FnSubu  = 6'h23,
    FnAnd   = 6'h24,
    FnOr    = 6'h25,
    FnSlt   = 6'h2a
  } functE;

  typedef enum logic [3:0] {
    AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll, AluSrl, AluLui
  } aluOpE;

  typedef enum logic [2:0] {
    PcSeq, PcBeq, PcBne, PcJump, PcJr
  } pcSrcE;

  // Newest stage wins when several hold the operand
  typedef enum logic [1:0] {
    FwdReg, FwdExMem, FwdMemWb
  } fwdSelE;

  typedef enum logic [1:0] {
    WbAlu, WbMem, WbHi, WbLo
  } wbSelE;

endpackage
